// ==== include/plic_params.svh ====
`ifndef PLIC_PARAMS_SVH
`define PLIC_PARAMS_SVH

// sizes, source 0 is reserved
`define PLIC_NUM_SRC    8
`define PLIC_ID_W       3
`define PLIC_PRIO_W     3

// bus
`define PLIC_ADDR_W     12
`define PLIC_DATA_W     32

// register byte offsets
`define PLIC_OFS_PRIO   12'h000
`define PLIC_OFS_PEND   12'h080
`define PLIC_OFS_TYPE   12'h084
`define PLIC_OFS_POL    12'h088
`define PLIC_OFS_EN     12'h100
`define PLIC_OFS_TH     12'h200
`define PLIC_OFS_CLAIM  12'h204

`endif

// ==== hw/plic_pkg.sv ====
`include "plic_params.svh"

package plic_pkg;

    // ------------------------------------------------------------------
    // register port
    // ------------------------------------------------------------------
    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`PLIC_ADDR_W-1:0] paddr;
        logic [`PLIC_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [`PLIC_DATA_W-1:0] prdata;
        logic                    pready;
        logic                    pslverr;
    } apb_rsp_t;

    // ------------------------------------------------------------------
    // sources
    // ------------------------------------------------------------------
    typedef logic [`PLIC_NUM_SRC-1:0] src_vec_t;
    typedef logic [`PLIC_PRIO_W-1:0]  prio_t;
    typedef logic [`PLIC_ID_W-1:0]    src_id_t;

    typedef struct packed {
        logic lvl;      // 1: level, 0: edge
        logic act_low;
    } src_cfg_t;

endpackage

// ==== hw/plic_gateway.sv ====
`timescale 1ns/1ps

module plic_gateway (
    input  logic               clk,
    input  logic               rstn,
    input  logic               src_i,
    input  plic_pkg::src_cfg_t cfg_i,
    input  logic               claim_i,
    input  logic               cmplet_i,
    output logic               pend_o
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_PEND  = 2'b01,
        ST_CLAIM = 2'b10
    } gw_state_e;

    gw_state_e state_q;
    gw_state_e state_d;

    logic src_act;
    logic lvl_q;
    logic lvl_dly_q;
    logic edge_q;
    logic pol_dly_q;
    logic set_pend;
    logic cancel;

    assign src_act = src_i ^ cfg_i.act_low;

    // polarity-corrected level, its delayed copy and the rise flag
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            lvl_q     <= 1'b0;
            lvl_dly_q <= 1'b0;
            edge_q    <= 1'b0;
            pol_dly_q <= 1'b0;
        end else begin
            lvl_q     <= src_act;
            lvl_dly_q <= lvl_q;
            edge_q    <= lvl_q & ~lvl_dly_q;
            pol_dly_q <= cfg_i.act_low;
        end
    end

    assign set_pend = cfg_i.lvl ? lvl_q : edge_q;
    assign cancel   = (cfg_i.lvl & ~lvl_q) | (cfg_i.act_low ^ pol_dly_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  if (set_pend) state_d = ST_PEND;
            ST_PEND:  if (claim_i) state_d = ST_CLAIM;
                      else if (cancel) state_d = ST_IDLE;
            ST_CLAIM: if (cmplet_i) state_d = ST_IDLE;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) state_q <= ST_IDLE;
        else       state_q <= state_d;
    end

    assign pend_o = (state_q == ST_PEND);

endmodule

// ==== hw/plic_regs.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_regs (
    input  logic                    clk,
    input  logic                    rstn,
    input  plic_pkg::apb_req_t      apb_i,
    output logic [`PLIC_DATA_W-1:0] prdata_o,
    input  plic_pkg::src_vec_t      pend_i,
    input  plic_pkg::src_id_t       cur_id_i,
    output plic_pkg::src_cfg_t      cfg_o [`PLIC_NUM_SRC],
    output plic_pkg::prio_t         prio_o [`PLIC_NUM_SRC],
    output plic_pkg::src_vec_t      enable_o,
    output plic_pkg::prio_t         threshold_o,
    output logic                    claim_rd_o,
    output logic                    claim_wr_o
);

    localparam int ADDR_W = `PLIC_ADDR_W;

    logic               setup;
    logic               wr_en;
    logic               rd_en;
    plic_pkg::src_vec_t prio_hit;
    logic               hit_pend;
    logic               hit_type;
    logic               hit_pol;
    logic               hit_en;
    logic               hit_th;
    logic               hit_claim;

    plic_pkg::prio_t    prio_q [`PLIC_NUM_SRC];
    plic_pkg::src_vec_t type_q;
    plic_pkg::src_vec_t pol_q;
    plic_pkg::src_vec_t en_q;
    plic_pkg::prio_t    th_q;

    logic [`PLIC_DATA_W-1:0] rd_word;
    logic [`PLIC_DATA_W-1:0] prdata_q;

    // ------------------------------------------------------------------
    // setup-phase decode
    // ------------------------------------------------------------------
    assign setup = apb_i.psel & ~apb_i.penable;
    assign wr_en = setup & apb_i.pwrite;
    assign rd_en = setup & ~apb_i.pwrite;

    always_comb begin
        prio_hit = '0; // source 0 has no priority register
        for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
            prio_hit[i] = (apb_i.paddr == `PLIC_OFS_PRIO + ADDR_W'(4 * i));
        end
    end

    assign hit_pend  = (apb_i.paddr == `PLIC_OFS_PEND);
    assign hit_type  = (apb_i.paddr == `PLIC_OFS_TYPE);
    assign hit_pol   = (apb_i.paddr == `PLIC_OFS_POL);
    assign hit_en    = (apb_i.paddr == `PLIC_OFS_EN);
    assign hit_th    = (apb_i.paddr == `PLIC_OFS_TH);
    assign hit_claim = (apb_i.paddr == `PLIC_OFS_CLAIM);

    assign claim_rd_o = rd_en & hit_claim;
    assign claim_wr_o = wr_en & hit_claim; // data is ignored

    // ------------------------------------------------------------------
    // config registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            for (int i = 0; i < `PLIC_NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            type_q <= '1; // level by default
            pol_q  <= '0;
            en_q   <= '0;
            th_q   <= '0;
        end else if (wr_en) begin
            for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
                if (prio_hit[i]) prio_q[i] <= apb_i.pwdata[`PLIC_PRIO_W-1:0];
            end
            if (hit_type) type_q <= apb_i.pwdata[`PLIC_NUM_SRC-1:0];
            if (hit_pol)  pol_q  <= apb_i.pwdata[`PLIC_NUM_SRC-1:0];
            if (hit_en)   en_q   <= apb_i.pwdata[`PLIC_NUM_SRC-1:0];
            if (hit_th)   th_q   <= apb_i.pwdata[`PLIC_PRIO_W-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < `PLIC_NUM_SRC; i++) begin
            cfg_o[i].lvl     = type_q[i];
            cfg_o[i].act_low = pol_q[i];
        end
    end

    assign prio_o      = prio_q;
    assign enable_o    = en_q;
    assign threshold_o = th_q;

    // ------------------------------------------------------------------
    // read mux, captured at the setup edge
    // ------------------------------------------------------------------
    always_comb begin
        rd_word = '0;
        for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
            rd_word[`PLIC_PRIO_W-1:0] |= prio_q[i] & {`PLIC_PRIO_W{prio_hit[i]}};
        end
        rd_word[`PLIC_NUM_SRC-1:0] |= pend_i & {`PLIC_NUM_SRC{hit_pend}};
        rd_word[`PLIC_NUM_SRC-1:0] |= type_q & {`PLIC_NUM_SRC{hit_type}};
        rd_word[`PLIC_NUM_SRC-1:0] |= pol_q  & {`PLIC_NUM_SRC{hit_pol}};
        rd_word[`PLIC_NUM_SRC-1:0] |= en_q   & {`PLIC_NUM_SRC{hit_en}};
        rd_word[`PLIC_PRIO_W-1:0]  |= th_q   & {`PLIC_PRIO_W{hit_th}};
        rd_word[`PLIC_ID_W-1:0]    |= cur_id_i & {`PLIC_ID_W{hit_claim}};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn)      prdata_q <= '0;
        else if (rd_en) prdata_q <= rd_word;
    end

    assign prdata_o = prdata_q;

endmodule

// ==== hw/plic_arbiter.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_arbiter (
    input  plic_pkg::src_vec_t pend_i,
    input  plic_pkg::src_vec_t enable_i,
    input  plic_pkg::prio_t    prio_i [`PLIC_NUM_SRC],
    output plic_pkg::src_id_t  best_id_o,
    output plic_pkg::prio_t    best_prio_o
);

    plic_pkg::prio_t   masked [`PLIC_NUM_SRC];
    plic_pkg::src_id_t best_id;
    plic_pkg::prio_t   best_prio;

    // only pending and enabled sources compete
    always_comb begin
        for (int i = 0; i < `PLIC_NUM_SRC; i++) begin
            masked[i] = (pend_i[i] & enable_i[i]) ? prio_i[i] : '0;
        end
    end

    // strictly greater wins, so ties keep the lower id
    always_comb begin
        best_id   = '0;
        best_prio = '0;
        for (int i = 0; i < `PLIC_NUM_SRC; i++) begin
            if (masked[i] > best_prio) begin
                best_id   = plic_pkg::src_id_t'(i);
                best_prio = masked[i];
            end
        end
    end

    assign best_id_o   = best_id;
    assign best_prio_o = best_prio;

endmodule

// ==== hw/plic_target.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_target (
    input  logic               clk,
    input  logic               rstn,
    input  plic_pkg::src_id_t  best_id_i,
    input  plic_pkg::prio_t    best_prio_i,
    input  plic_pkg::prio_t    threshold_i,
    input  logic               claim_rd_i,
    input  logic               claim_wr_i,
    output plic_pkg::src_id_t  cur_id_o,
    output plic_pkg::src_vec_t claim_vec_o,
    output plic_pkg::src_vec_t cmplet_vec_o,
    output logic               meip_o
);

    plic_pkg::src_id_t cur_id_q;
    plic_pkg::src_id_t claimed_q;
    plic_pkg::src_id_t cmplet_q;
    logic              claim_pls_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (~rstn) begin
            cur_id_q    <= '0;
            claimed_q   <= '0;
            cmplet_q    <= '0;
            claim_pls_q <= 1'b0;
        end else begin
            // non-preemptive, frozen while a source is claimed
            if (claim_wr_i) begin
                cur_id_q <= '0;
            end else if (!claim_rd_i && claimed_q == '0) begin
                cur_id_q <= (best_prio_i > threshold_i) ? best_id_i : '0;
            end
            if (claim_rd_i)      claimed_q <= cur_id_q;
            else if (claim_wr_i) claimed_q <= '0;
            cmplet_q    <= claim_wr_i ? claimed_q : '0; // write data plays no part
            claim_pls_q <= claim_rd_i;
        end
    end

    // one-hot pulses, id 0 has no gateway
    always_comb begin
        claim_vec_o  = '0;
        cmplet_vec_o = '0;
        for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
            claim_vec_o[i]  = claim_pls_q && (claimed_q == plic_pkg::src_id_t'(i));
            cmplet_vec_o[i] = (cmplet_q == plic_pkg::src_id_t'(i));
        end
    end

    assign cur_id_o = cur_id_q;
    assign meip_o   = (cur_id_q != claimed_q);

endmodule

// ==== hw/plic_top.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_top (
    input  logic               clk,
    input  logic               rstn,
    input  plic_pkg::apb_req_t apb_i,
    output plic_pkg::apb_rsp_t apb_o,
    input  plic_pkg::src_vec_t src_i,
    output logic               meip_o
);

    plic_pkg::src_cfg_t      cfg [`PLIC_NUM_SRC];
    plic_pkg::prio_t         prio [`PLIC_NUM_SRC];
    plic_pkg::src_vec_t      enable;
    plic_pkg::src_vec_t      pend;
    plic_pkg::src_vec_t      claim_vec;
    plic_pkg::src_vec_t      cmplet_vec;
    plic_pkg::prio_t         threshold;
    plic_pkg::prio_t         best_prio;
    plic_pkg::src_id_t       best_id;
    plic_pkg::src_id_t       cur_id;
    logic                    claim_rd;
    logic                    claim_wr;
    logic [`PLIC_DATA_W-1:0] prdata;

    // ------------------------------------------------------------------
    // gateways, source 0 reserved
    // ------------------------------------------------------------------
    assign pend[0] = 1'b0;

    for (genvar g = 1; g < `PLIC_NUM_SRC; g++) begin : g_gw
        plic_gateway i_plic_gateway (
            .clk      (clk),
            .rstn     (rstn),
            .src_i    (src_i[g]),
            .cfg_i    (cfg[g]),
            .claim_i  (claim_vec[g]),
            .cmplet_i (cmplet_vec[g]),
            .pend_o   (pend[g])
        );
    end

    plic_regs i_plic_regs (
        .clk         (clk),
        .rstn        (rstn),
        .apb_i       (apb_i),
        .prdata_o    (prdata),
        .pend_i      (pend),
        .cur_id_i    (cur_id),
        .cfg_o       (cfg),
        .prio_o      (prio),
        .enable_o    (enable),
        .threshold_o (threshold),
        .claim_rd_o  (claim_rd),
        .claim_wr_o  (claim_wr)
    );

    plic_arbiter i_plic_arbiter (
        .pend_i      (pend),
        .enable_i    (enable),
        .prio_i      (prio),
        .best_id_o   (best_id),
        .best_prio_o (best_prio)
    );

    plic_target i_plic_target (
        .clk          (clk),
        .rstn         (rstn),
        .best_id_i    (best_id),
        .best_prio_i  (best_prio),
        .threshold_i  (threshold),
        .claim_rd_i   (claim_rd),
        .claim_wr_i   (claim_wr),
        .cur_id_o     (cur_id),
        .claim_vec_o  (claim_vec),
        .cmplet_vec_o (cmplet_vec),
        .meip_o       (meip_o)
    );

    // never stalls, never errors
    assign apb_o = '{prdata: prdata, pready: 1'b1, pslverr: 1'b0};

endmodule

// ==== verif/plic_checker.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module plic_checker (
    input  logic               clk,
    input  logic               rstn,
    input  plic_pkg::apb_req_t apb_i,
    input  plic_pkg::apb_rsp_t apb_rsp_i,
    input  plic_pkg::src_vec_t src_i,
    input  logic               meip_i,
    input  logic               test_done_i,
    input  int                 test_num_i,
    input  logic               fail_i,
    output int                 chk_cnt_o,
    output int                 err_cnt_o
);

    localparam int NUM   = `PLIC_NUM_SRC;
    localparam int IDLE  = 0;
    localparam int PEND  = 1;
    localparam int CLAIM = 2;

    // model state
    int                      st [NUM];
    logic                    prev_act [NUM];
    plic_pkg::prio_t         prio [NUM];
    plic_pkg::src_vec_t      typ;
    plic_pkg::src_vec_t      pol;
    plic_pkg::src_vec_t      en;
    plic_pkg::prio_t         th;
    plic_pkg::src_id_t       claimed;
    plic_pkg::src_id_t       exp_id;

    logic                    rd_pend;
    logic                    claim_acc;
    logic [`PLIC_ADDR_W-1:0] rd_addr;
    logic [`PLIC_DATA_W-1:0] exp_word;

    int chk       = 0;
    int errs      = 0;
    int test_chk  = 0;
    int test_errs = 0;

    assign chk_cnt_o = chk;
    assign err_cnt_o = errs;

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        chk++;
        test_chk++;
        if (exp !== act) begin
            errs++;
            test_errs++;
            $display("** Error: %s expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < NUM; i++) begin
            st[i]       = IDLE;
            prev_act[i] = 1'b0;
            prio[i]     = '0;
        end
        typ     = '1;
        pol     = '0;
        en      = '0;
        th      = '0;
        claimed = '0;
    endtask

    function automatic plic_pkg::src_vec_t pend_vec();
        plic_pkg::src_vec_t v;
        v = '0;
        for (int i = 1; i < NUM; i++) v[i] = (st[i] == PEND);
        return v;
    endfunction

    // highest enabled pending priority above threshold with the lower id on ties
    function automatic plic_pkg::src_id_t best_claim();
        plic_pkg::src_id_t id;
        plic_pkg::prio_t   bp;
        id = '0;
        bp = '0;
        for (int i = 1; i < NUM; i++) begin
            if (st[i] == PEND && en[i] && prio[i] > bp) begin
                id = plic_pkg::src_id_t'(i);
                bp = prio[i];
            end
        end
        return (bp > th) ? id : '0;
    endfunction

    function automatic logic [31:0] read_model(input logic [`PLIC_ADDR_W-1:0] addr);
        logic [31:0] w;
        w = '0;
        for (int i = 1; i < NUM; i++) begin
            if (addr == `PLIC_OFS_PRIO + 4 * i) w[`PLIC_PRIO_W-1:0] = prio[i];
        end
        case (addr)
            `PLIC_OFS_PEND:  w[NUM-1:0] = pend_vec();
            `PLIC_OFS_TYPE:  w[NUM-1:0] = typ;
            `PLIC_OFS_POL:   w[NUM-1:0] = pol;
            `PLIC_OFS_EN:    w[NUM-1:0] = en;
            `PLIC_OFS_TH:    w[`PLIC_PRIO_W-1:0] = th;
            `PLIC_OFS_CLAIM: w[`PLIC_ID_W-1:0] = best_claim();
            default: ;
        endcase
        return w;
    endfunction

    task automatic write_model(input logic [`PLIC_ADDR_W-1:0] addr, input logic [31:0] data);
        for (int i = 1; i < NUM; i++) begin
            if (addr == `PLIC_OFS_PRIO + 4 * i) prio[i] = data[`PLIC_PRIO_W-1:0];
        end
        case (addr)
            `PLIC_OFS_TYPE: typ = data[NUM-1:0];
            `PLIC_OFS_POL: begin
                // any polarity change cancels a pending source
                for (int i = 1; i < NUM; i++) begin
                    if (st[i] == PEND && pol[i] != data[i]) st[i] = IDLE;
                end
                pol = data[NUM-1:0];
            end
            `PLIC_OFS_EN:    en = data[NUM-1:0];
            `PLIC_OFS_TH:    th = data[`PLIC_PRIO_W-1:0];
            `PLIC_OFS_CLAIM: begin
                if (claimed != '0) st[claimed] = IDLE;
                claimed = '0;
            end
            default: ;
        endcase
    endtask

    task automatic step_gateways(input plic_pkg::src_vec_t src);
        logic act;
        for (int i = 1; i < NUM; i++) begin
            act = src[i] ^ pol[i];
            if (st[i] == IDLE && (typ[i] ? act : (act && !prev_act[i]))) st[i] = PEND;
            else if (st[i] == PEND && typ[i] && !act) st[i] = IDLE;
            prev_act[i] = act;
        end
    endtask

    always @(posedge clk) begin
        if (!rstn) begin
            reset_model();
            rd_pend   = 1'b0;
            claim_acc = 1'b0;
        end else begin
            // port never stalls and never errors
            if (apb_i.psel && apb_i.penable) begin
                check_val("pready", 32'h1, apb_rsp_i.pready);
                check_val("pslverr", 32'h0, apb_rsp_i.pslverr);
            end
            // access phase of the previous read
            if (rd_pend) begin
                check_val($sformatf("prdata @0x%03h", rd_addr), exp_word, apb_rsp_i.prdata);
                if (claim_acc) check_val("meip_o after claim", 32'h0, meip_i);
                rd_pend   = 1'b0;
                claim_acc = 1'b0;
            end
            if (fail_i) begin
                errs++;
                test_errs++;
            end
            if (apb_i.psel && !apb_i.penable) begin
                if (apb_i.pwrite) begin
                    write_model(apb_i.paddr, apb_i.pwdata);
                end else begin
                    exp_word = read_model(apb_i.paddr);
                    rd_addr  = apb_i.paddr;
                    rd_pend  = 1'b1;
                    if (apb_i.paddr == `PLIC_OFS_CLAIM) begin
                        exp_id = best_claim();
                        check_val("meip_o at claim", 32'(exp_id != '0), meip_i);
                        if (exp_id != '0) st[exp_id] = CLAIM;
                        claimed   = exp_id;
                        claim_acc = 1'b1;
                    end
                end
            end
            step_gateways(src_i);
            if (test_done_i) begin
                $display("test %0d finished: %0d checks, %0d errors", test_num_i, test_chk,
                         test_errs);
                test_chk  = 0;
                test_errs = 0;
            end
        end
    end

endmodule

// ==== verif/tb_plic.sv ====
`timescale 1ns/1ps
`include "plic_params.svh"

module tb_plic;

    localparam int N_TESTS     = 6;
    localparam int MAX_TXN     = 200;  // per test
    localparam int TXN_CYCLES  = 10;
    localparam int CYCLE_LIMIT = N_TESTS * MAX_TXN * TXN_CYCLES * 2;

    logic               clk = 1'b0;
    logic               rstn;
    plic_pkg::apb_req_t apb;
    plic_pkg::apb_rsp_t apb_rsp;
    plic_pkg::src_vec_t src;
    logic               meip;

    logic test_done;
    int   test_num;
    logic fail;
    int   chk_cnt;
    int   err_cnt;
    int   cycles = 0;

    always #5 clk = ~clk;

    plic_top i_plic_top (
        .clk    (clk),
        .rstn   (rstn),
        .apb_i  (apb),
        .apb_o  (apb_rsp),
        .src_i  (src),
        .meip_o (meip)
    );

    plic_checker i_plic_checker (
        .clk         (clk),
        .rstn        (rstn),
        .apb_i       (apb),
        .apb_rsp_i   (apb_rsp),
        .src_i       (src),
        .meip_i      (meip),
        .test_done_i (test_done),
        .test_num_i  (test_num),
        .fail_i      (fail),
        .chk_cnt_o   (chk_cnt),
        .err_cnt_o   (err_cnt)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // bus and helper tasks that all end on a falling edge
    // ------------------------------------------------------------------
    task automatic apb_write(input logic [`PLIC_ADDR_W-1:0] addr, input logic [31:0] data);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b1;
        apb.paddr   = addr;
        apb.pwdata  = data;
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [`PLIC_ADDR_W-1:0] addr, output logic [31:0] data);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
        apb.paddr   = addr;
        @(negedge clk);
        apb.penable = 1'b1;
        @(negedge clk);
        data        = apb_rsp.prdata;
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic flag_fail(input string msg);
        $display("%s at %0t", msg, $time);
        fail = 1'b1;
        @(negedge clk);
        fail = 1'b0;
    endtask

    task automatic wait_meip(input int bound, output logic seen);
        int k;
        seen = 1'b0;
        k    = 0;
        while (!seen && k < bound) begin
            @(negedge clk);
            seen = meip;
            k++;
        end
    endtask

    task automatic end_test(input int n);
        test_num  = n;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    task automatic set_all_prio(input int lo, input int span);
        for (int i = 1; i < `PLIC_NUM_SRC; i++) begin
            apb_write(`PLIC_OFS_PRIO + 4 * i, lo + $urandom % span);
        end
    endtask

    function automatic plic_pkg::src_vec_t rand_src();
        plic_pkg::src_vec_t v;
        v = $urandom % 256;
        v[0] = 1'b0;
        if (v == '0) v = 8'h02;
        return v;
    endfunction

    // one-cycle pulse to the active level, then claim, complete, claim again
    task automatic edge_round(input int s);
        logic        seen;
        logic [31:0] rd;
        src[s] = ~src[s];
        @(negedge clk);
        src[s] = ~src[s];
        wait_meip(5, seen);
        if (!seen) flag_fail("edge source did not raise meip_o");
        apb_read(`PLIC_OFS_PEND, rd);
        apb_read(`PLIC_OFS_CLAIM, rd);
        apb_write(`PLIC_OFS_CLAIM, $urandom);
        repeat (6) @(negedge clk);
        apb_read(`PLIC_OFS_CLAIM, rd);
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0] rd;
        logic        seen;
        int          s;
        int          n;
        int          th;
        void'($urandom(32'h9d8b_7400));
        rstn      = 1'b0;
        apb       = '0;
        src       = '0;
        test_done = 1'b0;
        test_num  = 0;
        fail      = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;

        // test 1 reads reset values
        for (int i = 0; i < `PLIC_NUM_SRC; i++) apb_read(`PLIC_OFS_PRIO + 4 * i, rd);
        apb_read(`PLIC_OFS_PEND, rd);
        apb_read(`PLIC_OFS_TYPE, rd);
        apb_read(`PLIC_OFS_POL, rd);
        apb_read(`PLIC_OFS_EN, rd);
        apb_read(`PLIC_OFS_TH, rd);
        apb_read(`PLIC_OFS_CLAIM, rd);
        end_test(1);

        // test 2 random write and read back
        repeat (4) begin
            for (int i = 0; i < `PLIC_NUM_SRC; i++) begin
                apb_write(`PLIC_OFS_PRIO + 4 * i, $urandom);
                apb_read(`PLIC_OFS_PRIO + 4 * i, rd);
            end
            apb_write(`PLIC_OFS_TYPE, $urandom);
            apb_read(`PLIC_OFS_TYPE, rd);
            apb_write(`PLIC_OFS_POL, $urandom);
            apb_read(`PLIC_OFS_POL, rd);
            apb_write(`PLIC_OFS_EN, $urandom);
            apb_read(`PLIC_OFS_EN, rd);
            apb_write(`PLIC_OFS_TH, $urandom);
            apb_read(`PLIC_OFS_TH, rd);
            apb_write(12'h08c, $urandom);
            apb_read(12'h08c, rd);
            apb_write(12'h300, $urandom);
            apb_read(12'h300, rd);
            apb_read(12'h002, rd);
        end
        apb_write(`PLIC_OFS_TYPE, 32'hff);
        apb_write(`PLIC_OFS_POL, 32'h0);
        repeat (4) @(negedge clk);
        end_test(2);

        // test 3 level sources and a claim of the winner
        repeat (8) begin
            set_all_prio(1, 7);
            apb_write(`PLIC_OFS_EN, 32'hfe);
            apb_write(`PLIC_OFS_TH, 32'h0);
            src = rand_src();
            wait_meip(4, seen);
            if (!seen) flag_fail("meip_o did not rise for held level sources");
            repeat (2) @(negedge clk);
            apb_read(`PLIC_OFS_CLAIM, rd);
            src[rd[`PLIC_ID_W-1:0]] = 1'b0;
            apb_write(`PLIC_OFS_CLAIM, $urandom);
            src = '0;
            repeat (4) @(negedge clk);
        end
        end_test(3);

        // test 4 completes each claim until nothing is left
        repeat (6) begin
            set_all_prio(1, 7);
            src = rand_src();
            wait_meip(4, seen);
            if (!seen) flag_fail("meip_o did not rise for held level sources");
            repeat (2) @(negedge clk);
            apb_read(`PLIC_OFS_CLAIM, rd);
            n = 0;
            while (rd[`PLIC_ID_W-1:0] != '0 && n < 8) begin
                src[rd[`PLIC_ID_W-1:0]] = 1'b0;
                apb_write(`PLIC_OFS_CLAIM, $urandom);
                wait_meip(4, seen);
                // every held source is enabled and above the threshold
                if (seen != (src != '0)) begin
                    flag_fail("meip_o did not follow the pending sources after a completion");
                end
                repeat (2) @(negedge clk);
                apb_read(`PLIC_OFS_CLAIM, rd);
                n++;
            end
            if (rd[`PLIC_ID_W-1:0] != '0) flag_fail("claim register never returned to 0");
        end
        end_test(4);

        // test 5 edge sources active high and then active low
        repeat (3) begin
            s = 1 + $urandom % 7;
            apb_write(`PLIC_OFS_EN, 32'h1 << s);
            apb_write(`PLIC_OFS_PRIO + 4 * s, 1 + $urandom % 7);
            apb_write(`PLIC_OFS_TYPE, 32'hff & ~(32'h1 << s));
            edge_round(s);
            // switch to active low as a level source so no edge is seen
            apb_write(`PLIC_OFS_TYPE, 32'hff);
            src[s] = 1'b1;
            repeat (4) @(negedge clk);
            apb_write(`PLIC_OFS_POL, 32'h1 << s);
            repeat (4) @(negedge clk);
            apb_write(`PLIC_OFS_TYPE, 32'hff & ~(32'h1 << s));
            edge_round(s);
            apb_write(`PLIC_OFS_TYPE, 32'hff);
            src = '0;
            repeat (4) @(negedge clk);
            apb_write(`PLIC_OFS_POL, 32'h0);
            repeat (4) @(negedge clk);
        end
        end_test(5);

        // test 6 priorities at or below the threshold
        apb_write(`PLIC_OFS_EN, 32'hfe);
        repeat (3) begin
            th = 1 + $urandom % 7;
            apb_write(`PLIC_OFS_TH, th);
            set_all_prio(1, th);
            src = rand_src();
            n = 0;
            repeat (6) begin
                @(negedge clk);
                if (meip) n++;
            end
            if (n != 0) flag_fail("meip_o rose for sources not above the threshold");
            apb_read(`PLIC_OFS_PEND, rd);
            apb_read(`PLIC_OFS_CLAIM, rd);
            src = '0;
            repeat (4) @(negedge clk);
        end
        end_test(6);

        repeat (2) @(negedge clk);
        $display("all tests finished: %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
hw/plic_pkg.sv
hw/plic_gateway.sv
hw/plic_regs.sv
hw/plic_arbiter.sv
hw/plic_target.sv
hw/plic_top.sv
verif/plic_checker.sv
verif/tb_plic.sv
